//--- cmd_decoder.sv
// commands are opcode then argument; a command takes effect on its argument byte, no back-pressure.
`timescale 1ns/10ps

module cmd_decoder import corr_pkg::*; #(
	parameter int window_unit = 16
) (
	input  logic                  intclk,
	input  logic                  rst_n,
	input  logic                  cmd_valid,
	input  logic [7:0]            cmd_data,
	output logic [win_bits-1:0]   window,
	output logic [num_inputs-1:0] invert,
	output logic                  start
);

	typedef enum logic {
		st_opcode,
		st_arg
	} state_t;

	state_t state;
	opcode_t op_q;
	logic arg_byte;

	assign arg_byte = cmd_valid && (state == st_arg);

	// opcode is just held until its argument comes in.
	always_ff @(posedge intclk) begin
		if (cmd_valid && state == st_opcode) begin
			op_q <= opcode_t'(cmd_data);
		end
	end

	always_ff @(posedge intclk) begin
		if (!rst_n) begin
			state <= st_opcode;
			window <= win_bits'(window_unit);
			invert <= '0;
			start <= 1'b0;
		end else begin
			start <= 1'b0; // single cycle pulse.
			if (cmd_valid) begin
				state <= (state == st_opcode) ? st_arg : st_opcode;
			end
			if (arg_byte) begin
				case (op_q)
					op_set_window: begin
						if (cmd_data != 8'h00) begin // zero keeps the old length.
							window <= win_bits'(cmd_data * window_unit);
						end
					end
					op_set_invert: begin
						invert <= cmd_data[num_inputs-1:0];
					end
					op_start: begin
						start <= 1'b1;
					end
					default: begin
						// nop and unknown codes.
					end
				endcase
			end
		end
	end

endmodule

//--- corr_assert.sv
// bound into the packetizer, where the credit counter and both sides of the frame handover are visible.
`timescale 1ns/10ps

module corr_assert #(
	parameter int cred_bits = 1,
	parameter int data_bits = 224
) (
	input logic                 intclk,
	input logic                 rst_n,
	input logic [cred_bits-1:0] credits,
	input logic                 out_valid,
	input logic                 frame_valid,
	input logic                 frame_taken,
	input logic [data_bits-1:0] frame_data
);

	a_no_credit: assert property (@(posedge intclk) disable iff (!rst_n)
		out_valid |-> credits != '0)
		else $error("out_valid high with zero credits");

	// frame is frozen until the packetizer lets go of it.
	a_frame_stable: assert property (@(posedge intclk) disable iff (!rst_n)
		frame_valid && !frame_taken |=> $stable(frame_data))
		else $error("frame data changed while frame_valid was waiting");

	a_taken_valid: assert property (@(posedge intclk) disable iff (!rst_n)
		frame_taken |-> frame_valid)
		else $error("frame_taken high without frame_valid");

endmodule

bind packetizer corr_assert #(
	.cred_bits(cred_bits)
) i_assert (
	.intclk     (intclk),
	.rst_n      (rst_n),
	.credits    (credits),
	.out_valid  (out_valid),
	.frame_valid(frm.frame_valid),
	.frame_taken(frm.frame_taken),
	.frame_data ({frm.crosses, frm.autos, frm.counts})
);

//--- corr_checker.sv
// watches top-level ports only; expects inputs to change on the rising edge after sampling.
`timescale 1ns/10ps

module corr_checker import corr_pkg::*; #(
	parameter int window_unit = 16,
	parameter int max_credits = 4
) (
	input logic       intclk,
	input logic       rst_n,
	input logic [3:0] line_in,
	input logic       cmd_valid,
	input logic [7:0] cmd_data,
	input logic       out_valid,
	input logic [7:0] out_data,
	input logic       credit_return
);

	int errors;
	int pkt_done;
	int byte_idx; // position inside the current packet.
	logic [7:0] exp_q[$];

	int m_state; // 0 idle, 1 run, 2 hold.
	int remain;
	int m_cred;
	logic arg_next;
	logic [7:0] op_byte;
	logic [15:0] m_win;
	logic [3:0] m_mask;
	logic [3:0] prev;
	logic start_q; // decoder start register.
	logic taken_q; // frame_taken as the correlator will see it.
	int cnt[4];
	int aut[4];
	int crs[6];

	function automatic logic [15:0] field_val(int k);
		if (k < 4) begin
			return 16'(cnt[k]);
		end else if (k < 8) begin
			return 16'(aut[k-4]);
		end
		return 16'(crs[k-8]);
	endfunction

	function automatic void push_packet();
		logic [7:0] csum;
		logic [15:0] val;
		csum = 8'h00;
		exp_q.push_back(8'hA5);
		for (int k = 0; k < 14; k++) begin
			val = field_val(k);
			exp_q.push_back(val[15:8]);
			exp_q.push_back(val[7:0]);
			csum = csum ^ val[15:8] ^ val[7:0];
		end
		exp_q.push_back(csum);
	endfunction

	task automatic report_missing();
		if (exp_q.size() != 0) begin
			$display("%0d expected packet bytes never arrived", exp_q.size());
			errors++;
		end
		if (byte_idx != 0) begin
			$display("last packet stopped after %0d bytes", byte_idx);
			errors++;
		end
	endtask

	always @(posedge intclk) begin : model
		logic [3:0] s;
		logic [7:0] e;
		int p;
		if (!rst_n) begin
			m_state = 0;
			remain = 0;
			m_cred = max_credits;
			arg_next = 1'b0;
			m_win = 16'(window_unit);
			m_mask = 4'h0;
			start_q = 1'b0;
			taken_q = 1'b0;
			byte_idx = 0;
			exp_q.delete();
		end else begin
			// correlator step uses last cycle's decoder state.
			case (m_state)
				0: begin
					if (start_q) begin
						m_state = 1;
						remain = int'(m_win);
						prev = 4'h0;
						for (int i = 0; i < 4; i++) begin
							cnt[i] = 0;
							aut[i] = 0;
						end
						for (int i = 0; i < 6; i++) begin
							crs[i] = 0;
						end
					end
				end
				1: begin
					if (remain != 0) begin
						s = line_in ^ m_mask;
						p = 0;
						for (int i = 0; i < 4; i++) begin
							cnt[i] += int'(s[i]);
							aut[i] += int'(s[i] & prev[i]);
							for (int j = i + 1; j < 4; j++) begin
								crs[p] += int'(s[i] & s[j]);
								p++;
							end
						end
						prev = s;
						remain--;
					end else begin
						m_state = 2;
						push_packet();
					end
				end
				default: begin
					if (taken_q) begin
						m_state = 0;
						taken_q = 1'b0;
					end
				end
			endcase
			// output side.
			if (out_valid) begin
				if (m_cred == 0) begin
					$display("out_valid at %0t while no credit was left", $time);
					errors++;
				end
				if (exp_q.size() == 0) begin
					$display("unexpected extra byte %02h at %0t", out_data, $time);
					errors++;
				end else begin
					e = exp_q.pop_front();
					if (out_data !== e) begin
						$display("Fail at %0t: out_data byte %0d expected %02h got %02h",
							$time, byte_idx, e, out_data);
						errors++;
					end
					byte_idx++;
					if (byte_idx == pkt_bytes) begin
						byte_idx = 0;
						pkt_done++;
						taken_q = 1'b1;
					end
				end
			end
			m_cred = m_cred - int'(out_valid) + int'(credit_return);
			// command decoder.
			start_q = 1'b0;
			if (cmd_valid) begin
				if (!arg_next) begin
					op_byte = cmd_data;
					arg_next = 1'b1;
				end else begin
					arg_next = 1'b0;
					if (op_byte == 8'h01 && cmd_data != 8'h00) begin
						m_win = 16'(cmd_data * window_unit);
					end else if (op_byte == 8'h02) begin
						m_mask = cmd_data[3:0];
					end else if (op_byte == 8'h03) begin
						start_q = 1'b1;
					end
				end
			end
		end
	end

endmodule

//--- corr_pkg.sv
// four lines and the 30-byte packet layout are fixed together; res_bits must stay 16.
package corr_pkg;

	localparam int num_inputs = 4; // packet layout depends on this.
	localparam int num_pairs = 6;
	localparam int res_bits = 16;
	localparam int win_bits = 16; // window length register width.

	// cross pairs are numbered (0,1), (0,2), (0,3), (1,2), (1,3), (2,3).
	localparam int pair_lo [num_pairs] = '{0, 0, 0, 1, 1, 2};
	localparam int pair_hi [num_pairs] = '{1, 2, 3, 2, 3, 3};

	// command opcodes, first byte of a two-byte command.
	typedef enum logic [7:0] {
		op_nop        = 8'h00,
		op_set_window = 8'h01,
		op_set_invert = 8'h02,
		op_start      = 8'h03
	} opcode_t;

	// packet is header, 28 payload bytes high byte first, then xor of the payload.
	// payload field order is counts 0..3, autos 0..3, crosses 0..5.
	localparam logic [7:0] pkt_header = 8'hA5;
	localparam int pkt_bytes = 30;

endpackage

//--- corr_top.sv
// single clock domain; line_in is taken as already synchronous to intclk.
`timescale 1ns/10ps

module corr_top import corr_pkg::*; #(
	parameter int window_unit = 16,
	parameter int max_credits = 4
) (
	input  logic                  intclk,
	input  logic                  rst_n,
	input  logic [num_inputs-1:0] line_in,
	input  logic                  cmd_valid,
	input  logic [7:0]            cmd_data,
	output logic                  out_valid,
	output logic [7:0]            out_data,
	input  logic                  credit_return
);

	logic [win_bits-1:0] window;
	logic [num_inputs-1:0] invert;
	logic start;

	frame_if i_frm ();

	cmd_decoder #(
		.window_unit(window_unit)
	) i_cmd_decoder (
		.intclk   (intclk),
		.rst_n    (rst_n),
		.cmd_valid(cmd_valid),
		.cmd_data (cmd_data),
		.window   (window),
		.invert   (invert),
		.start    (start)
	);

	correlator i_correlator (
		.intclk (intclk),
		.rst_n  (rst_n),
		.line_in(line_in),
		.window (window),
		.invert (invert),
		.start  (start),
		.frm    (i_frm.producer)
	);

	packetizer #(
		.max_credits(max_credits)
	) i_packetizer (
		.intclk       (intclk),
		.rst_n        (rst_n),
		.frm          (i_frm.consumer),
		.out_valid    (out_valid),
		.out_data     (out_data),
		.credit_return(credit_return)
	);

endmodule

//--- correlator.sv
// starts are dropped unless idle; a window of W cycles takes W samples, counters cannot wrap.
`timescale 1ns/10ps

module correlator import corr_pkg::*; (
	input  logic                  intclk,
	input  logic                  rst_n,
	input  logic [num_inputs-1:0] line_in,
	input  logic [win_bits-1:0]   window,
	input  logic [num_inputs-1:0] invert,
	input  logic                  start,
	frame_if.producer             frm
);

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_hold
	} state_t;

	state_t state;
	logic [win_bits-1:0] remain; // samples still to take.
	logic [num_inputs-1:0] smp;
	logic [num_inputs-1:0] prev;
	logic clear;
	logic accum;

	assign smp = line_in ^ invert; // mask applies to the current sample only.
	assign clear = (state == st_idle) && start;
	assign accum = (state == st_run) && (remain != '0);

	always_ff @(posedge intclk) begin
		if (!rst_n) begin
			state <= st_idle;
			remain <= '0;
			frm.frame_valid <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (start) begin
						state <= st_run;
						remain <= window;
					end
				end
				st_run: begin
					if (remain != '0) begin
						remain <= remain - 1'b1;
					end else begin
						// last sample went in on the previous edge.
						state <= st_hold;
						frm.frame_valid <= 1'b1;
					end
				end
				st_hold: begin
					if (frm.frame_taken) begin
						state <= st_idle;
						frm.frame_valid <= 1'b0;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// accumulators double as the frame data, frozen outside run.
	always_ff @(posedge intclk) begin
		if (clear) begin
			prev <= '0; // first sample has no lag 1 partner.
			frm.counts <= '0;
			frm.autos <= '0;
			frm.crosses <= '0;
		end else if (accum) begin
			prev <= smp;
			for (int i = 0; i < num_inputs; i++) begin
				frm.counts[i] <= frm.counts[i] + res_bits'(smp[i]);
				frm.autos[i] <= frm.autos[i] + res_bits'(smp[i] & prev[i]);
			end
			for (int p = 0; p < num_pairs; p++) begin
				frm.crosses[p] <= frm.crosses[p]
					+ res_bits'(smp[pair_lo[p]] & smp[pair_hi[p]]);
			end
		end
	end

endmodule

//--- files.f
corr_pkg.sv
frame_if.sv
cmd_decoder.sv
correlator.sv
packetizer.sv
corr_top.sv
corr_checker.sv
corr_assert.sv
tb_corr.sv

//--- frame_if.sv
// one result frame at a time; data must not change while frame_valid waits for frame_taken.
`timescale 1ns/10ps

interface frame_if import corr_pkg::*; ();

	logic frame_valid; // held until frame_taken.
	logic frame_taken; // one cycle, after the last packet byte.
	logic [num_inputs-1:0][res_bits-1:0] counts;
	logic [num_inputs-1:0][res_bits-1:0] autos; // lag 1.
	logic [num_pairs-1:0][res_bits-1:0] crosses; // lag 0, pair order from the package.

	modport producer (
		output frame_valid,
		output counts,
		output autos,
		output crosses,
		input  frame_taken
	);

	modport consumer (
		input  frame_valid,
		input  counts,
		input  autos,
		input  crosses,
		output frame_taken
	);

endinterface

//--- packetizer.sv
// each out_valid cycle uses a credit, each credit_return cycle gives one back; no over-return check.
`timescale 1ns/10ps

module packetizer import corr_pkg::*; #(
	parameter int max_credits = 4
) (
	input  logic       intclk,
	input  logic       rst_n,
	frame_if.consumer  frm,
	output logic       out_valid,
	output logic [7:0] out_data,
	input  logic       credit_return
);

	localparam int cred_bits = $clog2(max_credits + 2);
	localparam int idx_bits = $clog2(pkt_bytes + 1);
	localparam int num_fields = 2 * num_inputs + num_pairs;

	logic [cred_bits-1:0] credits;
	logic [cred_bits-1:0] credits_next;
	logic [idx_bits-1:0] idx; // next byte to send, pkt_bytes once done.
	logic [idx_bits-1:0] pay_idx;
	logic [num_fields-1:0][res_bits-1:0] fields;
	logic [res_bits-1:0] field;
	logic [7:0] pay_byte;
	logic [7:0] next_byte;
	logic [7:0] csum;
	logic emit;

	// credits left once this cycle's byte and return are counted.
	assign credits_next = credits - cred_bits'(out_valid) + cred_bits'(credit_return);
	assign emit = frm.frame_valid && (idx < idx_bits'(pkt_bytes)) && (credits_next != '0);

	assign fields = {frm.crosses, frm.autos, frm.counts}; // counts end up at index 0.
	assign pay_idx = idx - 1'b1;
	assign field = fields[pay_idx[idx_bits-1:1]];
	assign pay_byte = pay_idx[0] ? field[7:0] : field[res_bits-1 -: 8]; // high byte first.

	always_comb begin
		if (idx == '0) begin
			next_byte = pkt_header;
		end else if (idx == idx_bits'(pkt_bytes - 1)) begin
			next_byte = csum;
		end else begin
			next_byte = pay_byte;
		end
	end

	always_ff @(posedge intclk) begin
		if (!rst_n) begin
			credits <= cred_bits'(max_credits);
			idx <= '0;
			out_valid <= 1'b0;
			frm.frame_taken <= 1'b0;
		end else begin
			credits <= credits_next;
			out_valid <= emit;
			// one cycle after the last byte was on the port.
			frm.frame_taken <= (idx == idx_bits'(pkt_bytes)) && !frm.frame_taken;
			if (frm.frame_taken) begin
				idx <= '0;
			end else if (emit) begin
				idx <= idx + 1'b1;
			end
		end
	end

	always_ff @(posedge intclk) begin
		if (emit) begin
			out_data <= next_byte;
			if (idx == '0) begin
				csum <= '0;
			end else if (idx < idx_bits'(pkt_bytes - 1)) begin
				csum <= csum ^ pay_byte; // running xor of payload.
			end
		end
	end

endmodule

//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it, pass only if the pass line shows up.
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_corr -f files.f -o sim_corr \
	&& ./obj_dir/sim_corr | tee /dev/stderr | grep -q "RESULT: PASS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- tb_corr.sv
// runs nine windows with random pulses; credit returns come after random gaps up to max_gap.
`timescale 1ns/10ps

module tb_corr import corr_pkg::*; ();

	localparam int window_unit = 16;
	localparam int max_credits = 4;
	localparam int max_gap = 12;
	localparam int n_windows = 9;
	localparam int cycle_limit = n_windows * (4080 + 30 * max_gap + 20) + 1000;

	logic intclk = 1'b0;
	logic rst_n;
	logic [3:0] line_in = 4'h0;
	logic cmd_valid;
	logic [7:0] cmd_data;
	logic out_valid;
	logic [7:0] out_data;
	logic credit_return = 1'b0;

	int n_exp;
	int tb_errors;
	int cycles;
	int owed;
	int gap;

	always #4 intclk = ~intclk;

	corr_top #(
		.window_unit(window_unit),
		.max_credits(max_credits)
	) i_corr_top (
		.intclk       (intclk),
		.rst_n        (rst_n),
		.line_in      (line_in),
		.cmd_valid    (cmd_valid),
		.cmd_data     (cmd_data),
		.out_valid    (out_valid),
		.out_data     (out_data),
		.credit_return(credit_return)
	);

	corr_checker #(
		.window_unit(window_unit),
		.max_credits(max_credits)
	) i_checker (
		.intclk       (intclk),
		.rst_n        (rst_n),
		.line_in      (line_in),
		.cmd_valid    (cmd_valid),
		.cmd_data     (cmd_data),
		.out_valid    (out_valid),
		.out_data     (out_data),
		.credit_return(credit_return)
	);

	always @(posedge intclk) begin
		line_in <= 4'($urandom);
	end

	// hand credits back one at a time after a random pause.
	always @(posedge intclk) begin
		if (!rst_n) begin
			owed = 0;
			gap = 0;
			credit_return <= 1'b0;
		end else begin
			owed = owed + int'(out_valid) - int'(credit_return);
			if (owed > 0 && gap == 0) begin
				credit_return <= 1'b1;
				gap = int'($urandom_range(0, max_gap));
			end else begin
				credit_return <= 1'b0;
				if (gap > 0) begin
					gap--;
				end
			end
		end
	end

	always @(posedge intclk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout, no finish after %0d cycles", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	task automatic send_cmd(input logic [7:0] op, input logic [7:0] arg);
		@(posedge intclk);
		cmd_valid <= 1'b1;
		cmd_data <= op;
		@(posedge intclk);
		cmd_data <= arg;
		@(posedge intclk);
		cmd_valid <= 1'b0;
	endtask

	task automatic wait_packet();
		while (i_checker.pkt_done < n_exp) begin
			@(posedge intclk);
		end
		repeat (4) @(posedge intclk);
	endtask

	task automatic run_window();
		send_cmd(op_start, 8'($urandom));
		n_exp++;
		wait_packet();
	endtask

	initial begin
		void'($urandom(30));
		rst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd_data = 8'h00;
		repeat (4) @(posedge intclk);
		rst_n <= 1'b1;

		run_window(); // default window and mask.

		repeat (4) begin
			send_cmd(op_set_window, 8'($urandom_range(1, 24)));
			send_cmd(op_set_invert, 8'($urandom));
			send_cmd(op_start, 8'h00);
			n_exp++;
			repeat ($urandom_range(2, 40)) @(posedge intclk);
			send_cmd(op_set_invert, 8'($urandom)); // lands mid-window.
			wait_packet();
		end
		send_cmd(op_set_window, 8'd255);
		run_window();

		// starts during a window and during a pending packet
		send_cmd(op_set_window, 8'd2);
		send_cmd(op_start, 8'h00);
		n_exp++;
		repeat (5) @(posedge intclk);
		send_cmd(op_start, 8'h00);
		while (i_checker.byte_idx < 5) begin
			@(posedge intclk);
		end
		send_cmd(op_start, 8'h00);
		wait_packet();
		repeat (80) @(posedge intclk);
		run_window();

		send_cmd(op_nop, 8'($urandom));
		send_cmd(8'h7E, 8'h03);
		send_cmd(op_set_window, 8'h00);
		run_window();

		repeat (50) @(posedge intclk);
		i_checker.report_missing();
		if (i_checker.pkt_done != n_exp) begin
			$display("got %0d packets, expected %0d", i_checker.pkt_done, n_exp);
			tb_errors++;
		end
		$display("errors: checker %0d, testbench %0d", i_checker.errors, tb_errors);
		if (i_checker.errors == 0 && tb_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule
